// File: design/branch_cfg.svh
// Branch unit widths, thread count and memory map, included by the RTL and the testbench
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define BR_PC_WIDTH        10
`define BR_WORD_WIDTH      32
`define BR_ADDR_WIDTH      10

// ----------------------------------------
// Threads
// ----------------------------------------
`define BR_THREAD_COUNT    4
`define BR_INITIAL_THREAD  0      // First thread to issue after reset

// ----------------------------------------
// Memory map, one entry per thread
// ----------------------------------------
`define BR_ORIGIN_BASE     10'h3F0 // Origins at 3F0..3F3
`define BR_DEST_BASE       10'h3F4 // Destinations at 3F4..3F7
`define BR_COND_BASE       10'h3F8 // Conditions at 3F8..3FB

// Field positions inside the ALU write word
`define BR_ORIGIN_OFFSET   0      // Bits 9:0
`define BR_DEST_OFFSET     10     // Bits 19:10
`define BR_COND_OFFSET     20     // Bits 22:20

`endif

// File: design/branch_pkg.sv
// Common branch unit types, imported by every RTL module and the testbench
`include "branch_cfg.svh"

package branch_pkg;

    // Width of a stored condition opcode
    localparam int COND_WIDTH = 3;

    // ----------------------------------------
    // Scalar types
    // ----------------------------------------
    typedef logic [`BR_PC_WIDTH-1:0]              pc_t;
    typedef logic [$clog2(`BR_THREAD_COUNT)-1:0]  thread_t;
    typedef logic [`BR_WORD_WIDTH-1:0]            word_t;
    typedef logic [`BR_ADDR_WIDTH-1:0]            addr_t;

    // ----------------------------------------
    // ALU flags of the issuing thread
    // ----------------------------------------
    typedef struct packed {
        logic zero;        // Bit 3
        logic negative;
        logic carry;
        logic overflow;    // Bit 0
    } br_flags_t;

    // ----------------------------------------
    // Branch conditions
    // ----------------------------------------
    // Zero encoding is NEVER, so a cleared table never branches
    typedef enum logic [COND_WIDTH-1:0] {
        COND_NEVER    = 3'd0,
        COND_ALWAYS   = 3'd1,
        COND_ZERO     = 3'd2,
        COND_NOT_ZERO = 3'd3,
        COND_NEG      = 3'd4,
        COND_POS      = 3'd5,  // Neither negative nor zero
        COND_CARRY    = 3'd6,
        COND_OVERFLOW = 3'd7
    } cond_op_e;

endpackage

// File: design/branch_map_decode.sv
// Memory map decoder that turns ALU register writes into branch table writes
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_map_decode (
    input  logic                 wr_en,
    input  branch_pkg::addr_t    wr_addr,
    input  branch_pkg::word_t    wr_data,

    output logic                 origin_we,
    output branch_pkg::thread_t  origin_idx,
    output branch_pkg::pc_t      origin_data,

    output logic                 dest_we,
    output branch_pkg::thread_t  dest_idx,
    output branch_pkg::pc_t      dest_data,

    output logic                 cond_we,
    output branch_pkg::thread_t  cond_idx,
    output branch_pkg::cond_op_e cond_op
);

    import branch_pkg::*;

    // True when addr falls in the per-thread window starting at base
    function automatic logic in_table(input addr_t addr, input addr_t base);
        addr_t offset;
        offset = addr - base;
        return (addr >= base) && (offset < addr_t'(`BR_THREAD_COUNT));
    endfunction

    // Zero-based entry inside the window
    function automatic thread_t entry_of(input addr_t addr, input addr_t base);
        addr_t offset;
        offset = addr - base;
        return thread_t'(offset);
    endfunction

    // ----------------------------------------
    // Write enables and entry indexes
    // ----------------------------------------
    always_comb begin
        origin_we  = wr_en && in_table(wr_addr, `BR_ORIGIN_BASE);
        dest_we    = wr_en && in_table(wr_addr, `BR_DEST_BASE);
        cond_we    = wr_en && in_table(wr_addr, `BR_COND_BASE);

        origin_idx = entry_of(wr_addr, `BR_ORIGIN_BASE);
        dest_idx   = entry_of(wr_addr, `BR_DEST_BASE);
        cond_idx   = entry_of(wr_addr, `BR_COND_BASE);
    end

    // ----------------------------------------
    // Data slices
    // ----------------------------------------
    // Each table owns its own field of the word, so one write word
    // may carry all three values at once
    always_comb begin
        origin_data = wr_data[`BR_ORIGIN_OFFSET +: `BR_PC_WIDTH];
        dest_data   = wr_data[`BR_DEST_OFFSET +: `BR_PC_WIDTH];
        cond_op     = cond_op_e'(wr_data[`BR_COND_OFFSET +: COND_WIDTH]);
    end

endmodule

// File: design/branch_exec.sv
// Branch execute stage with per-thread branch tables, the thread counter and branch evaluation
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_exec (
    input  logic                 clock,
    input  logic                 rst,

    input  branch_pkg::pc_t      pc,
    input  branch_pkg::br_flags_t flags,

    input  logic                 origin_we,
    input  branch_pkg::thread_t  origin_idx,
    input  branch_pkg::pc_t      origin_data,

    input  logic                 dest_we,
    input  branch_pkg::thread_t  dest_idx,
    input  branch_pkg::pc_t      dest_data,

    input  logic                 cond_we,
    input  branch_pkg::thread_t  cond_idx,
    input  branch_pkg::cond_op_e cond_op,

    output branch_pkg::thread_t  thread,
    output logic                 branch_taken,
    output branch_pkg::pc_t      taken_dest
);

    import branch_pkg::*;

    pc_t      origin_tbl [`BR_THREAD_COUNT];
    pc_t      dest_tbl   [`BR_THREAD_COUNT];
    cond_op_e cond_tbl   [`BR_THREAD_COUNT];

    logic     origin_hit;
    logic     cond_hold;
    cond_op_e cur_cond;

    // ----------------------------------------
    // Round-robin issue counter
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            thread <= thread_t'(`BR_INITIAL_THREAD);
        end else if (thread == thread_t'(`BR_THREAD_COUNT - 1)) begin
            thread <= '0;                    // Wrap to first thread
        end else begin
            thread <= thread + thread_t'(1);
        end
    end

    // ----------------------------------------
    // Branch tables
    // ----------------------------------------
    // Writes land at the clock edge and are seen from the next cycle on
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `BR_THREAD_COUNT; i++) begin
                origin_tbl[i] <= '0;
                dest_tbl[i]   <= '0;
                cond_tbl[i]   <= COND_NEVER;   // Nothing branches until programmed
            end
        end else begin
            if (origin_we) begin
                origin_tbl[origin_idx] <= origin_data;
            end
            if (dest_we) begin
                dest_tbl[dest_idx] <= dest_data;
            end
            if (cond_we) begin
                cond_tbl[cond_idx] <= cond_op;
            end
        end
    end

    // ----------------------------------------
    // Evaluation for the issuing thread
    // ----------------------------------------
    assign cur_cond   = cond_tbl[thread];
    assign origin_hit = (pc == origin_tbl[thread]);

    always_comb begin
        case (cur_cond)
            COND_NEVER:    cond_hold = 1'b0;
            COND_ALWAYS:   cond_hold = 1'b1;
            COND_ZERO:     cond_hold = flags.zero;
            COND_NOT_ZERO: cond_hold = !flags.zero;
            COND_NEG:      cond_hold = flags.negative;
            COND_POS:      cond_hold = !flags.negative && !flags.zero;
            COND_CARRY:    cond_hold = flags.carry;
            COND_OVERFLOW: cond_hold = flags.overflow;
            default:       cond_hold = 1'b0;
        endcase
    end

    assign branch_taken = origin_hit && cond_hold;
    assign taken_dest   = dest_tbl[thread];  // Presented even when not taken

endmodule

// File: design/branch_result.sv
// Branch result stage that registers the jump and cancels it when the last I/O access stalled
`timescale 1ns/1ps

module branch_result (
    input  logic             clock,
    input  logic             rst,

    input  logic             branch_taken,
    input  branch_pkg::pc_t  taken_dest,
    input  logic             io_ready_prev,

    output logic             jump,
    output branch_pkg::pc_t  branch_destination
);

    logic jump_accept;

    // ----------------------------------------
    // Cancel on I/O not ready
    // ----------------------------------------
    // An instruction whose I/O was not ready gets replayed by the
    // pipeline, so its branch must not redirect the thread now
    assign jump_accept = branch_taken && io_ready_prev;

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            jump               <= 1'b0;
            branch_destination <= '0;
        end else begin
            jump <= jump_accept;                     // One cycle after the PC
            if (jump_accept) begin
                branch_destination <= taken_dest;    // Holds otherwise
            end
        end
    end

endmodule

// File: design/branch_unit.sv
// Top level of the memory-mapped branch unit, placed beside the barrel-threaded pipeline
`timescale 1ns/1ps

module branch_unit (
    input  logic                  clock,
    input  logic                  rst,

    input  branch_pkg::pc_t       pc,
    input  branch_pkg::br_flags_t flags,
    input  logic                  io_ready_prev,

    input  logic                  wr_en,
    input  branch_pkg::addr_t     wr_addr,
    input  branch_pkg::word_t     wr_data,

    output branch_pkg::thread_t   thread,
    output logic                  jump,
    output branch_pkg::pc_t       branch_destination
);

    import branch_pkg::*;

    // Table write path, decode to execute
    logic     origin_we;
    thread_t  origin_idx;
    pc_t      origin_data;
    logic     dest_we;
    thread_t  dest_idx;
    pc_t      dest_data;
    logic     cond_we;
    thread_t  cond_idx;
    cond_op_e cond_op;

    // Raw outcome, execute to result
    logic     branch_taken;
    pc_t      taken_dest;

    // ----------------------------------------
    branch_map_decode decode_inst (
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .origin_we   (origin_we),
        .origin_idx  (origin_idx),
        .origin_data (origin_data),
        .dest_we     (dest_we),
        .dest_idx    (dest_idx),
        .dest_data   (dest_data),
        .cond_we     (cond_we),
        .cond_idx    (cond_idx),
        .cond_op     (cond_op)
    );

    // ----------------------------------------
    branch_exec exec_inst (
        .clock        (clock),
        .rst          (rst),
        .pc           (pc),
        .flags        (flags),
        .origin_we    (origin_we),
        .origin_idx   (origin_idx),
        .origin_data  (origin_data),
        .dest_we      (dest_we),
        .dest_idx     (dest_idx),
        .dest_data    (dest_data),
        .cond_we      (cond_we),
        .cond_idx     (cond_idx),
        .cond_op      (cond_op),
        .thread       (thread),
        .branch_taken (branch_taken),
        .taken_dest   (taken_dest)
    );

    // ----------------------------------------
    branch_result result_inst (
        .clock              (clock),
        .rst                (rst),
        .branch_taken       (branch_taken),
        .taken_dest         (taken_dest),
        .io_ready_prev      (io_ready_prev),
        .jump               (jump),
        .branch_destination (branch_destination)
    );

endmodule

// File: test/branch_unit_props.sv
// Concurrent assertions on the branch unit ports, bound into every branch_unit instance
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_unit_props (
    input logic                clock,
    input logic                rst,
    input logic                jump,
    input logic                io_ready_prev,
    input branch_pkg::thread_t thread
);

    import branch_pkg::*;

    // ----------------------------------------
    // Result stage
    // ----------------------------------------
    jump_low_after_reset: assert property (@(posedge clock) rst |=> !jump)
        else $error("jump is high in the cycle after reset");

    // A jump only follows an instruction whose I/O was ready
    jump_needs_io_ready: assert property (
        @(posedge clock) disable iff (rst) jump |-> $past(io_ready_prev)
    ) else $error("jump is high although io_ready_prev was low one cycle before");

    // ----------------------------------------
    // Thread counter
    // ----------------------------------------
    thread_round_robin: assert property (
        @(posedge clock) disable iff (rst)
        !rst |=> thread == thread_t'((int'($past(thread)) + 1) % `BR_THREAD_COUNT)
    ) else $error("thread did not advance by one");

endmodule

bind branch_unit branch_unit_props props_inst (
    .clock         (clock),
    .rst           (rst),
    .jump          (jump),
    .io_ready_prev (io_ready_prev),
    .thread        (thread)
);

// File: test/branch_unit_tb.sv
// Self-checking testbench for the branch unit that runs with the sources listed in build.f
`timescale 1ns/1ps
`include "branch_cfg.svh"

module branch_unit_tb;

    import branch_pkg::*;

    localparam int  RESET_CYCLES = 8;
    localparam int  RANDOM_ROWS  = 40;
    localparam pc_t T2_ORIGIN    = 10'h155;  // Thread 2 program used by tests 2 to 5
    localparam pc_t T2_DEST      = 10'h0C3;
    localparam pc_t T2_DEST_NEW  = 10'h3A0;

    // One cycle of stimulus with the outcome expected one cycle later
    typedef struct packed {
        logic [2:0] test;
        logic       wr_en;
        addr_t      wr_addr;
        word_t      wr_data;
        pc_t        pc;
        br_flags_t  flags;
        logic       io_ready;
        logic       exp_jump;
        pc_t        exp_dest;
    } row_t;

    logic      clock;
    logic      rst;
    pc_t       pc;
    br_flags_t flags;
    logic      io_ready_prev;
    logic      wr_en;
    addr_t     wr_addr;
    word_t     wr_data;
    thread_t   thread;
    logic      jump;
    pc_t       branch_destination;

    row_t      rows [$];
    pc_t       ref_origin [`BR_THREAD_COUNT];  // Reference copy of the tables
    pc_t       ref_dest   [`BR_THREAD_COUNT];
    cond_op_e  ref_cond   [`BR_THREAD_COUNT];
    pc_t       ref_last_dest;
    thread_t   exp_thread;
    int        seed = 32'h08fa4bac;
    int        error_count = 0;
    int        check_count = 0;
    int        test_errors = 0;
    int        cycle_count = 0;
    int        timeout_limit = 0;

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    branch_unit branch_unit_inst (.*);

    // ----------------------------------------
    // Reference rules
    // ----------------------------------------
    function automatic word_t pack_word(input cond_op_e c, input pc_t dest, input pc_t origin);
        word_t w;
        w = '0;
        w[`BR_ORIGIN_OFFSET +: `BR_PC_WIDTH] = origin;
        w[`BR_DEST_OFFSET +: `BR_PC_WIDTH]   = dest;
        w[`BR_COND_OFFSET +: 3]              = c;
        return w;
    endfunction

    function automatic addr_t slot_addr(input int base, input int t);
        return addr_t'(base + t);
    endfunction

    // Entry of a table window or -1 outside it
    function automatic int table_slot(input addr_t addr, input int base);
        int offset;
        offset = int'(addr) - base;
        if (offset >= 0 && offset < `BR_THREAD_COUNT) return offset;
        return -1;
    endfunction

    function automatic logic cond_holds(input cond_op_e c, input br_flags_t f);
        case (c)
            COND_ALWAYS:   return 1'b1;
            COND_ZERO:     return f.zero;
            COND_NOT_ZERO: return !f.zero;
            COND_NEG:      return f.negative;
            COND_POS:      return !f.negative && !f.zero;
            COND_CARRY:    return f.carry;
            COND_OVERFLOW: return f.overflow;
            default:       return 1'b0;  // COND_NEVER
        endcase
    endfunction

    function automatic string test_title(input int n);
        case (n)
            1:       return "reset state";
            2:       return "table programming";
            3:       return "condition opcodes";
            4:       return "origin mismatch and stray writes";
            5:       return "io cancel";
            default: return "random pcs per thread";
        endcase
    endfunction

    task automatic model_write(input logic en, input addr_t addr, input word_t data);
        int slot;
        if (!en) return;
        slot = table_slot(addr, `BR_ORIGIN_BASE);
        if (slot >= 0) ref_origin[slot] = data[`BR_ORIGIN_OFFSET +: `BR_PC_WIDTH];
        slot = table_slot(addr, `BR_DEST_BASE);
        if (slot >= 0) ref_dest[slot] = data[`BR_DEST_OFFSET +: `BR_PC_WIDTH];
        slot = table_slot(addr, `BR_COND_BASE);
        if (slot >= 0) ref_cond[slot] = cond_op_e'(data[`BR_COND_OFFSET +: 3]);
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    task automatic add_row(input int test, input logic en, input addr_t addr, input word_t data,
                           input pc_t row_pc, input br_flags_t f, input logic io,
                           input logic exp_jump, input pc_t exp_dest);
        row_t r;
        r = '{3'(test), en, addr, data, row_pc, f, io, exp_jump, exp_dest};
        rows.push_back(r);
        model_write(en, addr, data);
        ref_last_dest = exp_dest;
    endtask

    task automatic add_idle(input int test, input pc_t row_pc, input br_flags_t f, input logic io,
                            input logic exp_jump, input pc_t exp_dest);
        add_row(test, 1'b0, '0, '0, row_pc, f, io, exp_jump, exp_dest);
    endtask

    task automatic add_write(input int test, input addr_t addr, input word_t data,
                             input pc_t row_pc, input pc_t exp_dest);
        add_row(test, 1'b1, addr, data, row_pc, 4'b0000, 1'b1, 1'b0, exp_dest);
    endtask

    // Eight rows from thread 0 where thread 2 sees flag set a then flag set b
    task automatic add_cond_check(input cond_op_e c, input br_flags_t fa, input logic ja,
                                  input br_flags_t fb, input logic jb);
        add_write(3, slot_addr(`BR_COND_BASE, 2), pack_word(c, 10'h3FF, 10'h3FF), '0, T2_DEST);
        for (int k = 1; k < 8; k++) begin
            if (k == 2) add_idle(3, T2_ORIGIN, fa, 1'b1, ja, T2_DEST);
            else if (k == 6) add_idle(3, T2_ORIGIN, fb, 1'b1, jb, T2_DEST);
            else add_idle(3, 10'h000, 4'b0000, 1'b1, 1'b0, T2_DEST);
        end
    endtask

    task automatic add_random_row();
        thread_t   t;
        pc_t       row_pc;
        br_flags_t f;
        logic      io;
        logic      hit;
        t = thread_t'((rows.size() + `BR_INITIAL_THREAD) % `BR_THREAD_COUNT);
        if ($random(seed) & 1) row_pc = ref_origin[t];  // Aim at the origin half the time
        else row_pc = pc_t'($random(seed));
        f   = br_flags_t'($random(seed));
        io  = (($random(seed) & 3) != 0);
        hit = (row_pc == ref_origin[t]) && cond_holds(ref_cond[t], f) && io;
        add_idle(6, row_pc, f, io, hit, hit ? ref_dest[t] : ref_last_dest);
    endtask

    task automatic build_table();
        pc_t      prog_origin [4] = '{10'h011, 10'h122, 10'h233, 10'h344};
        pc_t      prog_dest   [4] = '{10'h2A0, 10'h2B1, 10'h2C2, 10'h2D3};
        cond_op_e prog_cond   [4] = '{COND_ALWAYS, COND_ZERO, COND_CARRY, COND_POS};
        word_t    stray;
        stray = pack_word(COND_ALWAYS, 10'h200, 10'h000);
        add_idle(1, 10'h000, 4'b1111, 1'b1, 1'b0, 10'h000);
        add_idle(1, 10'h3FF, 4'b1111, 1'b1, 1'b0, 10'h000);
        add_idle(1, 10'h155, 4'b1111, 1'b1, 1'b0, 10'h000);
        add_idle(1, 10'h000, 4'b1111, 1'b1, 1'b0, 10'h000);
        add_write(2, slot_addr(`BR_ORIGIN_BASE, 2),
                  pack_word(COND_OVERFLOW, 10'h2AA, T2_ORIGIN), 10'h000, 10'h000);
        add_write(2, slot_addr(`BR_DEST_BASE, 2),
                  pack_word(COND_ALWAYS, T2_DEST, 10'h3FF), 10'h000, 10'h000);
        add_write(2, slot_addr(`BR_COND_BASE, 2),
                  pack_word(COND_ALWAYS, 10'h111, 10'h222), T2_ORIGIN, 10'h000);
        for (int k = 0; k < 3; k++) add_idle(2, T2_ORIGIN, 4'b0000, 1'b1, 1'b0, 10'h000);
        add_idle(2, T2_ORIGIN, 4'b0000, 1'b1, 1'b1, T2_DEST);
        add_idle(2, T2_ORIGIN, 4'b0000, 1'b1, 1'b0, T2_DEST);
        // Flags are zero, negative, carry, overflow from the top bit down
        add_cond_check(COND_NEVER,    4'b1111, 1'b0, 4'b0000, 1'b0);
        add_cond_check(COND_ALWAYS,   4'b0000, 1'b1, 4'b1111, 1'b1);
        add_cond_check(COND_ZERO,     4'b1000, 1'b1, 4'b0111, 1'b0);
        add_cond_check(COND_NOT_ZERO, 4'b0111, 1'b1, 4'b1000, 1'b0);
        add_cond_check(COND_NEG,      4'b0100, 1'b1, 4'b1011, 1'b0);
        add_cond_check(COND_POS,      4'b0011, 1'b1, 4'b0100, 1'b0);
        add_cond_check(COND_POS,      4'b1000, 1'b0, 4'b0001, 1'b1);  // Zero alone also fails
        add_cond_check(COND_CARRY,    4'b0010, 1'b1, 4'b1101, 1'b0);
        add_cond_check(COND_OVERFLOW, 4'b0001, 1'b1, 4'b1110, 1'b0);
        add_write(4, slot_addr(`BR_COND_BASE, 2),
                  pack_word(COND_ALWAYS, 10'h3FF, 10'h3FF), 10'h000, T2_DEST);
        add_write(4, 10'h3EF, stray, 10'h000, T2_DEST);
        add_write(4, 10'h3FC, stray, 10'h154, T2_DEST);
        add_row(4, 1'b0, `BR_COND_BASE, stray, 10'h000, 4'b0000, 1'b1, 1'b0, T2_DEST);
        for (int k = 0; k < 6; k++) begin
            add_idle(4, (k % 4 == 2) ? 10'h156 : 10'h000, 4'b0000, 1'b1, 1'b0, T2_DEST);
        end
        add_idle(4, T2_ORIGIN, 4'b0000, 1'b1, 1'b1, T2_DEST);
        add_idle(4, 10'h000, 4'b0000, 1'b1, 1'b0, T2_DEST);
        add_write(5, slot_addr(`BR_DEST_BASE, 2),
                  pack_word(COND_NEVER, T2_DEST_NEW, 10'h000), 10'h000, T2_DEST);
        add_idle(5, 10'h000, 4'b0000, 1'b1, 1'b0, T2_DEST);
        add_idle(5, T2_ORIGIN, 4'b0000, 1'b0, 1'b0, T2_DEST);  // Cancelled while dest holds
        add_idle(5, 10'h000, 4'b0000, 1'b0, 1'b0, T2_DEST);
        add_idle(5, 10'h000, 4'b0000, 1'b1, 1'b0, T2_DEST);
        add_idle(5, 10'h000, 4'b0000, 1'b1, 1'b0, T2_DEST);
        add_idle(5, T2_ORIGIN, 4'b0000, 1'b1, 1'b1, T2_DEST_NEW);
        add_idle(5, 10'h000, 4'b0000, 1'b0, 1'b0, T2_DEST_NEW);
        for (int t = 0; t < `BR_THREAD_COUNT; t++) begin
            add_write(6, slot_addr(`BR_ORIGIN_BASE, t),
                      pack_word(COND_NEVER, '0, prog_origin[t]), 10'h3FF, T2_DEST_NEW);
            add_write(6, slot_addr(`BR_DEST_BASE, t),
                      pack_word(COND_NEVER, prog_dest[t], '0), 10'h3FF, T2_DEST_NEW);
            add_write(6, slot_addr(`BR_COND_BASE, t),
                      pack_word(prog_cond[t], '0, '0), 10'h3FF, T2_DEST_NEW);
        end
        for (int k = 0; k < RANDOM_ROWS; k++) add_random_row();
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_jump(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s jump %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_dest(input pc_t got, input pc_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s destination %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_thread(input thread_t got, input thread_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s thread %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic drive_row(input row_t r);
        wr_en         = r.wr_en;
        wr_addr       = r.wr_addr;
        wr_data       = r.wr_data;
        pc            = r.pc;
        flags         = r.flags;
        io_ready_prev = r.io_ready;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst           = 1'b1;
        pc            = '0;
        flags         = '0;
        io_ready_prev = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        for (int t = 0; t < `BR_THREAD_COUNT; t++) begin
            ref_origin[t] = '0;
            ref_dest[t]   = '0;
            ref_cond[t]   = COND_NEVER;
        end
        ref_last_dest = '0;
        build_table();
        timeout_limit = RESET_CYCLES + rows.size() * 2 + 50;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        check_jump(jump, 1'b0, "after reset");
        check_dest(branch_destination, '0, "after reset");
        exp_thread = thread_t'(`BR_INITIAL_THREAD);
        for (int i = 0; i <= rows.size(); i++) begin
            if (i > 0) begin  // Outcome of the previous row one cycle after its PC
                check_jump(jump, rows[i-1].exp_jump, $sformatf("row %0d", i - 1));
                check_dest(branch_destination, rows[i-1].exp_dest, $sformatf("row %0d", i - 1));
                if (i == rows.size() || rows[i].test != rows[i-1].test) begin
                    $display("Test %0d (%s) finished with %0d errors", rows[i-1].test,
                             test_title(rows[i-1].test), error_count - test_errors);
                    test_errors = error_count;
                end
            end
            if (i < rows.size()) begin
                check_thread(thread, exp_thread, $sformatf("row %0d", i));
                drive_row(rows[i]);
                exp_thread = (exp_thread == thread_t'(`BR_THREAD_COUNT - 1)) ? '0
                                                                             : exp_thread + 1'b1;
                @(negedge clock);
            end
        end
        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Cycle limit against a stuck run
    always @(posedge clock) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("The run timed out after %0d cycles", cycle_count);
            $display("test failed");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+design
design/branch_pkg.sv
design/branch_map_decode.sv
design/branch_exec.sv
design/branch_result.sv
design/branch_unit.sv
test/branch_unit_props.sv
test/branch_unit_tb.sv

// File: Bender.yml
package:
  name: branch_unit

sources:
  # Design sources in compile order
  - include_dirs:
      - design
    files:
      - design/branch_pkg.sv
      - design/branch_map_decode.sv
      - design/branch_exec.sv
      - design/branch_result.sv
      - design/branch_unit.sv

  # Testbench and bound assertions
  - target: test
    include_dirs:
      - design
    files:
      - test/branch_unit_props.sv
      - test/branch_unit_tb.sv
